// ==== sim/conVectors.txt ====
# cond magic ebus ds (octal) | ctl groups c1 c2 c3 (binary) | expected e1 e2 e3 e4 (binary)
# c1 cc,sync,memF,cycReq,fetch,ldVma c2 fm,mb,pgErr,skip,flagCtl,save c3 diag,nicond..mtrInt
14 000 00 0 000000 000000 000000000 00000000000 000100 000000 00010010
16 000 00 0 000000 000000 000000000 10000000000 000000 000000 00010010
25 000 00 0 000000 000000 000000000 01000000000 000000 000000 00010010
32 000 00 0 000000 000000 000000000 00100000000 000000 000000 00010010
35 000 00 0 000000 000000 000000000 00000000000 000010 000000 00010010
36 000 00 0 000000 000000 000000000 00000000000 000001 000000 00010010
20 040 00 0 000000 000000 000000000 00000000001 000000 000000 00010010
20 014 17 0 010000 000000 000000000 00010011110 000000 000000 00010010
20 014 17 0 000000 000000 000000000 00000000000 000000 000000 00010010
20 015 17 0 010000 000000 000000000 00001000000 000000 000000 00010010
20 016 66 0 000000 000000 000000000 00000100000 000000 000000 00010010
00 000 00 0 000000 000000 000000000 00000000000 000000 000000 11100010
20 016 00 0 100000 000000 000000000 00000000000 000000 000000 11100010
20 016 00 0 000000 000000 000000000 00000100000 000000 000000 11100010
00 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010010
00 000 00 0 001100 000000 000000000 00000000000 000000 000000 00010010
00 000 00 0 001000 000000 000000000 00000000000 110000 000000 00010010
00 000 00 0 001000 010000 000000000 00000000000 110000 000000 00010010
00 000 00 0 001000 000000 000000000 00000000000 000000 000000 00010010
00 000 00 0 001110 000000 000000000 00000000000 000000 000000 00010010
00 000 00 0 001010 000000 000000000 00000000000 110100 000000 00010010
00 000 00 0 001000 001000 000000000 00000000000 110000 000000 00010010
00 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010010
15 502 00 0 000000 000000 000000000 00000000000 000000 000000 00010010
00 000 00 0 000000 000000 000000000 00000000000 001000 110000 00010010
65 000 00 0 000000 000000 000000000 00000000000 001000 110000 00010011
00 000 00 0 000000 000100 000000000 00000000000 001000 110000 00010010
00 000 00 0 000000 000000 000000000 00000000000 000000 110000 00010010
15 000 00 0 000000 000000 000000000 00000000000 000000 110000 00010010
00 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010010
21 252 00 0 000000 000000 000000000 00000000000 000000 000000 00010010
00 000 00 0 000000 000000 000000000 00000000000 000000 001111 00010010
21 125 00 0 000000 000000 000000000 00000000000 000000 001111 00010010
00 000 00 0 000000 000000 000000000 00000000000 000000 001111 00010010
21 000 00 0 000000 000000 000000000 00000000000 000000 001111 00010010
00 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010010
00 000 00 1 000000 000000 100000000 00000000000 000000 000000 00010010
00 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010010
00 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010010
00 000 00 0 000000 000000 000000000 00000000000 000000 000000 00011010
00 000 00 0 000000 000000 100000000 00000000000 000000 000000 00011010
00 000 00 0 000000 000000 000000000 00000000000 000000 000000 00011010
00 000 00 0 000000 000000 000000000 00000000000 000000 000000 00011010
00 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010010
00 000 00 2 000000 000000 100000000 00000000000 000000 000000 00010010
00 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010010
00 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010010
00 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010110
60 000 00 0 000010 000000 000000000 00000000000 000000 000000 00010111
61 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010111
62 000 00 0 000000 000000 001000000 00000000000 000000 000000 00010100
63 000 00 0 000000 000000 000100000 00000000000 000000 000000 00010100
64 000 00 0 000000 000000 000010000 00000000000 000000 000000 00010111
65 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010110
66 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010111
67 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010111
70 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010110
71 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010110
72 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010110
73 000 00 0 000000 000000 000001000 00000000000 000000 000000 00010111
74 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010110
75 000 00 0 000000 000000 000000100 00000000000 000000 000000 00010111
76 000 00 0 000000 000000 000000010 00000000000 000000 000000 00010111
77 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010111
77 000 00 0 000000 000000 000000001 00000000000 000000 000000 00010110
00 000 00 2 000000 000000 100000000 00000000000 000000 000000 00010110
00 000 00 1 000000 000000 100000000 00000000000 000000 000000 00010110
00 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010110
71 000 00 0 000000 000000 000000000 00000000000 000000 000000 00010011
72 000 00 0 000000 000000 000000000 00000000000 000000 000000 00011011

// ==== flist.f ====
verilog/conPkg.sv
verilog/conCondDecode.sv
verilog/conMagicDecode.sv
verilog/conCycleCtl.sv
verilog/conModeRegs.sv
verilog/conSkipSelect.sv
verilog/conTop.sv
sim/conTb.sv

// ==== sim/conTb.sv ====
`timescale 1ns/100ps

module conTb;
  import conPkg::*;

  logic                       conCLK;
  logic                       CLK;
  logic [condWidth-1:0]       condField;
  magicField                  magic;
  logic                       consoleControl, eboxSync, memField, mboxCycReq;
  logic                       vmaFetch, loadVma, fmXfer, mbXfer, pageError;
  logic                       skipSatisfied, specFlagCtl, specSaveFlags;
  logic                       diagCtlFunc, dispNicond, user, public, rdPseWr;
  logic                       ioLegal, vmaSection0, acRef, mtrIntReq;
  logic [ebusCtlWidth-1:0]    ebusData;
  logic [dsWidth-1:0]         diagDs;
  logic                       condSrMagic, condLongEn, condVmaMagic;
  logic                       conoApr, conoPi, conoPag, selEn, selDis, selClr, selSet;
  logic                       delayReq, memCycle, mboxWait, piCycle, loadIr;
  logic [1:0]                 vmaSel;
  logic                       pcPlus1Inh, eboxHalted;
  logic [ucodeStateWidth-1:0] ucodeState;
  logic                       cacheLookEn, cacheLoadEn, trapEn, ki10PagingMode;
  logic                       run, start, kernelMode, condAdr10;
  logic [30:0]                gotOut;

  int    cycleCount;
  int    cycleLimit;
  string vectorLines[$];

  // Output names indexed by bit position in gotOut
  string outNames [30:0] = '{
    "condSrMagic", "condLongEn", "condVmaMagic", "conoApr", "conoPi", "conoPag",
    "selEn", "selDis", "selClr", "selSet", "delayReq", "memCycle", "mboxWait",
    "piCycle", "loadIr", "vmaSel[1]", "vmaSel[0]", "pcPlus1Inh", "eboxHalted",
    "ucodeState[3]", "ucodeState[2]", "ucodeState[1]", "ucodeState[0]",
    "cacheLookEn", "cacheLoadEn", "trapEn", "ki10PagingMode", "run", "start",
    "kernelMode", "condAdr10"
  };

  conTop dut (.*);

  assign gotOut = {condSrMagic, condLongEn, condVmaMagic, conoApr, conoPi, conoPag,
                   selEn, selDis, selClr, selSet, delayReq, memCycle, mboxWait,
                   piCycle, loadIr, vmaSel, pcPlus1Inh, eboxHalted, ucodeState,
                   cacheLookEn, cacheLoadEn, trapEn, ki10PagingMode, run, start,
                   kernelMode, condAdr10};

  initial conCLK = 1'b0;
  always #5 conCLK = ~conCLK;

  always @(posedge conCLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: the vectors did not finish within %0d cycles", cycleLimit);
      $display("Test failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  task automatic checkValue(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          fields;
    string       line;
    logic [5:0]  vCond;
    logic [8:0]  vMagic;
    logic [5:0]  vEbus;
    logic [2:0]  vDs;
    logic [5:0]  c1;
    logic [5:0]  c2;
    logic [8:0]  c3;
    logic [10:0] e1;
    logic [5:0]  e2;
    logic [5:0]  e3;
    logic [7:0]  e4;
    logic [30:0] expOut;

    cycleCount = 0;
    cycleLimit = 1000;
    CLK = 1'b1;
    condField = '0;
    magic = '0;
    ebusData = '0;
    diagDs = '0;
    {consoleControl, eboxSync, memField, mboxCycReq, vmaFetch, loadVma} = '0;
    {fmXfer, mbXfer, pageError, skipSatisfied, specFlagCtl, specSaveFlags} = '0;
    {diagCtlFunc, dispNicond, user, public, rdPseWr, ioLegal} = '0;
    {vmaSection0, acRef, mtrIntReq} = '0;

    fd = $fopen("sim/conVectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file sim/conVectors.txt");
      $display("Test failed");
      $fatal(1, "No vectors");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 4 && line.substr(0, 0) != "#") begin
        vectorLines.push_back(line);
      end
    end
    $fclose(fd);
    cycleLimit = vectorLines.size() + 20;

    repeat (5) @(posedge conCLK);
    CLK <= 1'b0;

    foreach (vectorLines[i]) begin
      fields = $sscanf(vectorLines[i], "%o %o %o %o %b %b %b %b %b %b %b",
                       vCond, vMagic, vEbus, vDs, c1, c2, c3, e1, e2, e3, e4);
      if (fields != 11) begin
        $display("Vector line %0d could not be read", i);
        $display("Test failed");
        $fatal(1, "Bad vector line");
      end
      @(posedge conCLK);
      condField <= vCond;
      magic     <= vMagic;
      ebusData  <= vEbus;
      diagDs    <= vDs;
      {consoleControl, eboxSync, memField, mboxCycReq, vmaFetch, loadVma} <= c1;
      {fmXfer, mbXfer, pageError, skipSatisfied, specFlagCtl, specSaveFlags} <= c2;
      {diagCtlFunc, dispNicond, public, user, rdPseWr, ioLegal,
       vmaSection0, acRef, mtrIntReq} <= c3;
      // Registers and decode settled by mid-cycle
      @(negedge conCLK);
      expOut = {e1, e2, e3, e4};
      for (int b = 0; b < 31; b++) begin
        if (expOut[b] !== 1'bx) begin
          checkValue(outNames[b], gotOut[b], expOut[b]);
        end
      end
    end

    $display("Test passed");
    $finish;
  end

endmodule

// ==== verilog/conTop.sv ====
`timescale 1ns/100ps

module conTop (
  input  logic                               conCLK,
  input  logic                               CLK,
  input  logic [conPkg::condWidth-1:0]       condField,
  input  conPkg::magicField                  magic,
  input  logic                               consoleControl,
  input  logic                               eboxSync,
  input  logic [conPkg::ebusCtlWidth-1:0]    ebusData,
  input  logic                               memField,
  input  logic                               mboxCycReq,
  input  logic                               vmaFetch,
  input  logic                               loadVma,
  input  logic                               fmXfer,
  input  logic                               mbXfer,
  input  logic                               pageError,
  input  logic                               skipSatisfied,
  input  logic                               specFlagCtl,
  input  logic                               specSaveFlags,
  input  logic                               diagCtlFunc,
  input  logic [conPkg::dsWidth-1:0]         diagDs,
  input  logic                               dispNicond,
  input  logic                               user,
  input  logic                               public,
  input  logic                               rdPseWr,
  input  logic                               ioLegal,
  input  logic                               vmaSection0,
  input  logic                               acRef,
  input  logic                               mtrIntReq,
  output logic                               condSrMagic,
  output logic                               condLongEn,
  output logic                               condVmaMagic,
  output logic                               conoApr,
  output logic                               conoPi,
  output logic                               conoPag,
  output logic                               selEn,
  output logic                               selDis,
  output logic                               selClr,
  output logic                               selSet,
  output logic                               delayReq,
  output logic                               memCycle,
  output logic                               mboxWait,
  output logic                               piCycle,
  output logic                               loadIr,
  output logic [1:0]                         vmaSel,
  output logic                               pcPlus1Inh,
  output logic                               eboxHalted,
  output logic [conPkg::ucodeStateWidth-1:0] ucodeState,
  output logic                               cacheLookEn,
  output logic                               cacheLoadEn,
  output logic                               trapEn,
  output logic                               ki10PagingMode,
  output logic                               run,
  output logic                               start,
  output logic                               kernelMode,
  output logic                               condAdr10
);

  logic condSpecInstr;
  logic condLoadIr;
  logic condDiagFunc;
  logic condEboxState;
  logic condVmaInc;
  logic condVmaDec;
  logic condSkip6x;
  logic condSkip7x;

  conCondDecode uCondDecode (
    .condField,
    .condSpecInstr,
    .condLoadIr,
    .condSrMagic,
    .condDiagFunc,
    .condEboxState,
    .condLongEn,
    .condVmaInc,
    .condVmaDec,
    .condVmaMagic,
    .condSkip6x,
    .condSkip7x
  );

  conMagicDecode uMagicDecode (
    .conCLK, .CLK, .magic, .condDiagFunc, .consoleControl, .eboxSync, .ebusData,
    .conoApr, .conoPi, .conoPag, .selEn, .selDis, .selClr, .selSet, .delayReq
  );

  conCycleCtl uCycleCtl (
    .conCLK, .CLK, .magic, .memField, .mboxCycReq, .vmaFetch, .loadVma,
    .fmXfer, .mbXfer, .pageError, .skipSatisfied, .specFlagCtl, .specSaveFlags,
    .eboxSync, .condSpecInstr, .condLoadIr, .condVmaInc, .condVmaDec,
    .memCycle, .mboxWait, .piCycle, .loadIr, .vmaSel
  );

  conModeRegs uModeRegs (
    .conCLK, .CLK, .magic, .ebusData, .diagCtlFunc, .diagDs, .dispNicond,
    .condSpecInstr, .condEboxState, .conoPag, .user, .public,
    .pcPlus1Inh, .eboxHalted, .ucodeState, .cacheLookEn, .cacheLoadEn,
    .trapEn, .ki10PagingMode, .run, .start, .kernelMode
  );

  conSkipSelect uSkipSelect (
    .CLK, .condField, .condSkip6x, .condSkip7x, .vmaFetch, .kernelMode,
    .user, .public, .rdPseWr, .piCycle, .start, .run, .ioLegal,
    .vmaSection0, .acRef, .mtrIntReq, .condAdr10
  );

endmodule

// ==== verilog/conSkipSelect.sv ====
`timescale 1ns/100ps

module conSkipSelect (
  input  logic                         CLK,
  input  logic [conPkg::condWidth-1:0] condField,
  input  logic                         condSkip6x,
  input  logic                         condSkip7x,
  input  logic                         vmaFetch,
  input  logic                         kernelMode,
  input  logic                         user,
  input  logic                         public,
  input  logic                         rdPseWr,
  input  logic                         piCycle,
  input  logic                         start,
  input  logic                         run,
  input  logic                         ioLegal,
  input  logic                         vmaSection0,
  input  logic                         acRef,
  input  logic                         mtrIntReq,
  output logic                         condAdr10
);

  logic [2:0] member;
  logic [7:0] skip6xIn;
  logic [7:0] skip7xIn;
  logic       skip6xSel;
  logic       skip7xSel;

  assign member = condField[2:0];

  // Member 0 in the low bit; EBUS grant and PI transfer fixed at 1
  assign skip6xIn = {1'b1, 1'b1, piCycle, rdPseWr,
                     public, user, kernelMode, vmaFetch};

  // Interrupt request and PXCT fixed at 0
  assign skip7xIn = {~mtrIntReq, acRef, vmaSection0, 1'b0,
                     ioLegal, run, ~start, 1'b0};

  assign skip6xSel = skip6xIn[member];
  assign skip7xSel = skip7xIn[member];

  assign condAdr10 = (condSkip6x & skip6xSel) |
                     (condSkip7x & skip7xSel & ~CLK);

endmodule

// ==== verilog/conModeRegs.sv ====
`timescale 1ns/100ps

module conModeRegs (
  input  logic                               conCLK,
  input  logic                               CLK,
  input  conPkg::magicField                  magic,
  input  logic [conPkg::ebusCtlWidth-1:0]    ebusData,
  input  logic                               diagCtlFunc,
  input  logic [conPkg::dsWidth-1:0]         diagDs,
  input  logic                               dispNicond,
  input  logic                               condSpecInstr,
  input  logic                               condEboxState,
  input  logic                               conoPag,
  input  logic                               user,
  input  logic                               public,
  output logic                               pcPlus1Inh,
  output logic                               eboxHalted,
  output logic [conPkg::ucodeStateWidth-1:0] ucodeState,
  output logic                               cacheLookEn,
  output logic                               cacheLoadEn,
  output logic                               trapEn,
  output logic                               ki10PagingMode,
  output logic                               run,
  output logic                               start,
  output logic                               kernelMode
);
  import conPkg::*;

  logic [magicWidth-1:0] magicBits;
  logic                  loadSpecInstr;
  logic                  kl10PagingEn;
  logic                  diagSetRun;
  logic                  diagClrRun;
  logic                  diagContinue;
  logic                  run1;
  logic                  run2;
  logic                  start1;
  logic                  start2;

  assign magicBits     = magic;
  assign loadSpecInstr = dispNicond | condSpecInstr;

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      pcPlus1Inh <= 1'b0;
      eboxHalted <= 1'b0;
    end else if (loadSpecInstr) begin
      pcPlus1Inh <= magic.specFlags.pcPlus1Inh;
      eboxHalted <= magic.specFlags.eboxHalted;
    end
  end

  // Each state bit: odd MAGIC bit sets, even MAGIC bit holds, else clear
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      ucodeState <= '0;
    end else if (condEboxState) begin
      for (int i = 0; i < ucodeStateWidth; i++) begin
        ucodeState[i] <= magicBits[2*i+1] | (magicBits[2*i] & ucodeState[i]);
      end
    end
  end

  // CONO PAG
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      cacheLookEn  <= 1'b0;
      cacheLoadEn  <= 1'b0;
      kl10PagingEn <= 1'b0;
      trapEn       <= 1'b0;
    end else if (conoPag) begin
      cacheLookEn  <= ebusData[ebus18];
      cacheLoadEn  <= ebusData[ebus19];
      kl10PagingEn <= ebusData[ebus21];
      trapEn       <= ebusData[ebus22];
    end
  end

  assign ki10PagingMode = ~kl10PagingEn;
  assign kernelMode     = ~user & ~public;

  assign diagClrRun   = diagCtlFunc & (diagDs == dsClrRun);
  assign diagSetRun   = diagCtlFunc & (diagDs == dsSetRun);
  assign diagContinue = diagCtlFunc & (diagDs == dsContinue);

  // First stage holds the state, the other two only delay it
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      run1   <= 1'b0;
      run2   <= 1'b0;
      run    <= 1'b0;
      start1 <= 1'b0;
      start2 <= 1'b0;
      start  <= 1'b0;
    end else begin
      run1   <= diagSetRun | (~diagClrRun & run1);
      run2   <= run1;
      run    <= run2;
      start1 <= start1 ^ diagContinue;
      start2 <= start1;
      start  <= start2;
    end
  end

endmodule

// ==== verilog/conCycleCtl.sv ====
`timescale 1ns/100ps

module conCycleCtl (
  input  logic              conCLK,
  input  logic              CLK,
  input  conPkg::magicField magic,
  input  logic              memField,
  input  logic              mboxCycReq,
  input  logic              vmaFetch,
  input  logic              loadVma,
  input  logic              fmXfer,
  input  logic              mbXfer,
  input  logic              pageError,
  input  logic              skipSatisfied,
  input  logic              specFlagCtl,
  input  logic              specSaveFlags,
  input  logic              eboxSync,
  input  logic              condSpecInstr,
  input  logic              condLoadIr,
  input  logic              condVmaInc,
  input  logic              condVmaDec,
  output logic              memCycle,
  output logic              mboxWait,
  output logic              piCycle,
  output logic              loadIr,
  output logic [1:0]        vmaSel
);

  logic xfer;
  logic fetchCycle;
  logic dismiss;
  logic clrPiCycle;

  assign xfer = fmXfer | mbXfer;

  // Memory cycle open from the request until data moves or paging fails
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      memCycle <= 1'b0;
    end else begin
      memCycle <= mboxCycReq | (memCycle & ~xfer & ~pageError);
    end
  end

  assign mboxWait   = memField & memCycle;
  assign fetchCycle = vmaFetch & memCycle;

  assign loadIr = fetchCycle | condLoadIr;

  // Bit 1 selects decrement, bit 0 increment; both for a full VMA load
  assign vmaSel[1] = condVmaDec | loadVma;
  assign vmaSel[0] = condVmaInc | loadVma;

  // MAGIC bit 2 under flag control is a dismiss
  assign dismiss = specFlagCtl & magic.specFlags.pcPlus1Inh;

  assign clrPiCycle = (specSaveFlags & piCycle & eboxSync) | dismiss;

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      piCycle <= 1'b0;
    end else begin
      piCycle <= (condSpecInstr & magic.specFlags.piCycleSet) |
                 (piCycle & ~skipSatisfied & ~clrPiCycle);
    end
  end

endmodule

// ==== verilog/conMagicDecode.sv ====
`timescale 1ns/100ps

module conMagicDecode (
  input  logic                            conCLK,
  input  logic                            CLK,
  input  conPkg::magicField               magic,
  input  logic                            condDiagFunc,
  input  logic                            consoleControl,
  input  logic                            eboxSync,
  input  logic [conPkg::ebusCtlWidth-1:0] ebusData,
  output logic                            conoApr,
  output logic                            conoPi,
  output logic                            conoPag,
  output logic                            selEn,
  output logic                            selDis,
  output logic                            selClr,
  output logic                            selSet,
  output logic                            delayReq
);
  import conPkg::*;

  logic funcConoEn;
  logic conoAprDec;
  logic conoPiDec;
  logic conoPagDec;
  logic resetHold;
  logic forceStrobes;

  // CONO group only for the 0xx functions and not under console control
  assign funcConoEn = condDiagFunc & ~magic.diagFunc.mode &
                      (magic.diagFunc.funcGroup == funcCono) & ~consoleControl;

  assign conoAprDec = funcConoEn & (magic.diagFunc.subFunc == subConoApr);
  assign conoPiDec  = funcConoEn & (magic.diagFunc.subFunc == subConoPi);
  assign conoPagDec = funcConoEn & (magic.diagFunc.subFunc == subConoPag);

  // Strobes also held for the cycle in which reset drops
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      resetHold <= 1'b1;
    end else begin
      resetHold <= 1'b0;
    end
  end

  assign forceStrobes = CLK | resetHold;

  assign conoApr = eboxSync & (forceStrobes | conoAprDec);
  assign conoPi  = eboxSync & (forceStrobes | conoPiDec);
  assign conoPag = forceStrobes | conoPagDec;

  // APR select lines straight from the CONO data
  assign selEn  = ebusData[ebus20] & conoApr;
  assign selDis = ebusData[ebus21] & conoApr;
  assign selClr = ebusData[ebus22] & conoApr;
  assign selSet = ebusData[ebus23] & conoApr;

  // Any 04x..07x function asks for a delay
  assign delayReq = condDiagFunc & magic.diagFunc.funcGroup[2];

endmodule

// ==== verilog/conCondDecode.sv ====
`timescale 1ns/100ps

module conCondDecode (
  input  logic [conPkg::condWidth-1:0] condField,
  output logic                         condSpecInstr,
  output logic                         condLoadIr,
  output logic                         condSrMagic,
  output logic                         condDiagFunc,
  output logic                         condEboxState,
  output logic                         condLongEn,
  output logic                         condVmaInc,
  output logic                         condVmaDec,
  output logic                         condVmaMagic,
  output logic                         condSkip6x,
  output logic                         condSkip7x
);
  import conPkg::*;

  logic [2:0] grp;
  logic [2:0] member;
  logic       grp10;
  logic       grp20;
  logic       grp30;

  assign grp    = condField[condWidth-1 -: 3];
  assign member = condField[2:0];

  assign grp10 = (grp == condGrp10);
  assign grp20 = (grp == condGrp20);
  assign grp30 = (grp == condGrp30);

  // 1x group
  assign condLoadIr    = grp10 & (member == mbrLoadIr);
  assign condSpecInstr = grp10 & (member == mbrSpecInstr);
  assign condSrMagic   = grp10 & (member == mbrSrMagic);

  // 2x group
  assign condDiagFunc  = grp20 & (member == mbrDiagFunc);
  assign condEboxState = grp20 & (member == mbrEboxState);
  assign condLongEn    = grp20 & (member == mbrLongEn);

  // 3x group, codes 30 to 34 all take VMA from MAGIC
  assign condVmaMagic = grp30 & (member <= mbrVmaMagicMax);
  assign condVmaDec   = grp30 & (member == mbrVmaDec);
  assign condVmaInc   = grp30 & (member == mbrVmaInc);

  // Whole skip groups, member picked later
  assign condSkip6x = (grp == condGrp60);
  assign condSkip7x = (grp == condGrp70);

endmodule

// ==== verilog/conPkg.sv ====
package conPkg;

  // Microword and bus field widths
  localparam int condWidth       = 6;
  localparam int magicWidth      = 9;
  localparam int dsWidth         = 3;
  localparam int ebusCtlWidth    = 6;
  localparam int ucodeStateWidth = 4;

  // COND group codes, upper three bits of the field
  localparam logic [2:0] condGrp10 = 3'o1;
  localparam logic [2:0] condGrp20 = 3'o2;
  localparam logic [2:0] condGrp30 = 3'o3;
  localparam logic [2:0] condGrp60 = 3'o6;
  localparam logic [2:0] condGrp70 = 3'o7;

  // COND member codes inside a group
  localparam logic [2:0] mbrLoadIr      = 3'd4;
  localparam logic [2:0] mbrSpecInstr   = 3'd5;
  localparam logic [2:0] mbrSrMagic     = 3'd6;
  localparam logic [2:0] mbrDiagFunc    = 3'd0;
  localparam logic [2:0] mbrEboxState   = 3'd1;
  localparam logic [2:0] mbrLongEn      = 3'd5;
  localparam logic [2:0] mbrVmaMagicMax = 3'd4;
  localparam logic [2:0] mbrVmaDec      = 3'd5;
  localparam logic [2:0] mbrVmaInc      = 3'd6;

  // Diagnostic selector codes under DIAG CTL FUNC 01x
  localparam logic [2:0] dsClrRun   = 3'd0;
  localparam logic [2:0] dsSetRun   = 3'd1;
  localparam logic [2:0] dsContinue = 3'd2;

  // MAGIC function group 01x and its CONO sub-functions
  localparam logic [2:0] funcCono   = 3'b001;
  localparam logic [2:0] subConoApr = 3'd4;
  localparam logic [2:0] subConoPi  = 3'd5;
  localparam logic [2:0] subConoPag = 3'd6;

  // EBUS data bits 18..23, bit 18 is the most significant
  localparam int ebus18 = 5;
  localparam int ebus19 = 4;
  localparam int ebus20 = 3;
  localparam int ebus21 = 2;
  localparam int ebus22 = 1;
  localparam int ebus23 = 0;

  // MAGIC word, first member field is MAGIC bit 0
  typedef union packed {
    struct packed {
      logic [1:0] spare;
      logic       mode;
      logic [2:0] funcGroup;
      logic [2:0] subFunc;
    } diagFunc;
    struct packed {
      logic piCycleSet;
      logic kernelCycle;
      logic pcPlus1Inh;
      logic unused3;
      logic pxct;
      logic intDisable;
      logic instrAbort;
      logic eboxHalted;
      logic spec8;
    } specFlags;
  } magicField;

endpackage
